/* logic/capture_pkg.sv */
// Shared widths, sizes and types for the two-channel capture path.
// Imported by every RTL module and the stream interface.

package capture_pkg;

  // Width of one converter sample
  localparam int SAMPLE_W = 16;

  // Entries in each channel receive buffer
  localparam int BUF_DEPTH = 8;

  // Pointer width follows the depth
  localparam int BUF_PTR_W = $clog2(BUF_DEPTH);

  // One sample word as it travels through the path
  typedef logic [SAMPLE_W-1:0] sample_t;

  // Write or read pointer into a buffer bank
  typedef logic [BUF_PTR_W-1:0] buf_ptr_t;

  // Channel number carried on every merged beat
  typedef logic [0:0] chan_t;

endpackage

/* logic/sample_stream_if.sv */
// One ready/valid sample stream between a receive buffer and the merger.
// A beat moves on a rising edge with valid and ready both high.
`timescale 1ns/1ns

interface sample_stream_if import capture_pkg::*; ();

  logic    valid;
  logic    ready;
  logic    last;
  sample_t data;

  // Buffer side drives the payload and waits for ready
  modport source (
    output valid,
    output last,
    output data,
    input  ready
  );

  // Merger side grants ready
  // Last and data are zero whenever valid is low
  modport sink (
    input  valid,
    input  last,
    input  data,
    output ready
  );

endinterface

/* logic/stream_rx_buffer.sv */
// Receive buffer for one capture channel. Writes cannot stall, so the source keeps
// at most BUF_DEPTH samples outstanding; the read side is a registered stream.
`timescale 1ns/1ns

module stream_rx_buffer import capture_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  logic            ch_valid,
  input  logic            ch_last,
  input  sample_t         ch_data,
  sample_stream_if.source out
);

  // Bank written at wr_ptr on every valid sample
  sample_t  bank_data [BUF_DEPTH];
  logic     bank_last [BUF_DEPTH];

  buf_ptr_t wr_ptr;
  buf_ptr_t rd_ptr;

  // Entry under the read pointer
  sample_t  rd_data;
  logic     rd_last;

  // Read side control
  logic     rd_ready;
  logic     bank_empty;
  logic     rd_advance;

  always_ff @(posedge clk) begin
    if (ch_valid) begin
      bank_data[wr_ptr] <= ch_data;
      bank_last[wr_ptr] <= ch_last;
    end
  end

  // Write pointer moves with every sample
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
    end else if (ch_valid) begin
      wr_ptr <= wr_ptr + buf_ptr_t'(1);
    end
  end

  assign rd_data = bank_data[rd_ptr];
  assign rd_last = bank_last[rd_ptr];

  // Output register can load when it is empty or being taken this cycle
  assign rd_ready   = out.ready | ~out.valid;
  assign bank_empty = (rd_ptr == wr_ptr);
  assign rd_advance = rd_ready & ~bank_empty;

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr <= '0;
    end else if (rd_advance) begin
      rd_ptr <= rd_ptr + buf_ptr_t'(1);
    end
  end

  // Registered output stage
  // Holds under back-pressure, clears to zero when nothing is left
  always_ff @(posedge clk) begin
    if (rst) begin
      out.valid <= 1'b0;
      out.last  <= 1'b0;
      out.data  <= '0;
    end else if (rd_ready) begin
      if (!bank_empty) begin
        out.valid <= 1'b1;
        out.last  <= rd_last;
        out.data  <= rd_data;
      end else begin
        out.valid <= 1'b0;
        out.last  <= 1'b0;
        out.data  <= '0;
      end
    end
  end

endmodule

/* logic/packet_merge.sv */
// Round-robin merge of two channel streams into one tagged output stream.
// A packet is never split; the channel that just finished yields to the other.
`timescale 1ns/1ns

module packet_merge import capture_pkg::*; (
  input  logic          clk,
  input  logic          rst,
  sample_stream_if.sink ch0,
  sample_stream_if.sink ch1,
  output logic          out_valid,
  input  logic          out_ready,
  output logic          out_last,
  output sample_t       out_data,
  output chan_t         out_chan
);

  // IDLE has no channel selected, CH0 and CH1 are locked on a channel
  typedef enum logic [1:0] {
    MERGE_IDLE,
    MERGE_CH0,
    MERGE_CH1
  } merge_state_t;

  merge_state_t state;
  merge_state_t state_next;

  // Channel of the most recent finished packet
  chan_t   prev_chan;

  // Selected channel and its current beat
  chan_t   sel_chan;
  logic    sel_valid;
  logic    sel_last;
  sample_t sel_data;
  logic    other_valid;

  logic    out_free;
  logic    take;

  assign out_free = ~out_valid | out_ready;

  // Channel select
  always_comb begin
    case (state)
      MERGE_CH0: sel_chan = chan_t'(0);
      MERGE_CH1: sel_chan = chan_t'(1);
      default: begin
        // Tie goes to the channel that did not send last
        if (ch0.valid && ch1.valid) begin
          sel_chan = ~prev_chan;
        end else if (ch1.valid) begin
          sel_chan = chan_t'(1);
        end else begin
          sel_chan = chan_t'(0);
        end
      end
    endcase
  end

  always_comb begin
    if (sel_chan == chan_t'(1)) begin
      sel_valid   = ch1.valid;
      sel_last    = ch1.last;
      sel_data    = ch1.data;
      other_valid = ch0.valid;
    end else begin
      sel_valid   = ch0.valid;
      sel_last    = ch0.last;
      sel_data    = ch0.data;
      other_valid = ch1.valid;
    end
  end

  assign take = out_free & sel_valid;

  // Only the selected channel sees ready
  assign ch0.ready = out_free & (sel_chan == chan_t'(0));
  assign ch1.ready = out_free & (sel_chan == chan_t'(1));

  // Stay locked until the last beat, then hand over if the other side waits
  always_comb begin
    state_next = state;
    if (take) begin
      if (!sel_last) begin
        state_next = (sel_chan == chan_t'(1)) ? MERGE_CH1 : MERGE_CH0;
      end else if (other_valid) begin
        state_next = (sel_chan == chan_t'(1)) ? MERGE_CH0 : MERGE_CH1;
      end else begin
        state_next = MERGE_IDLE;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= MERGE_IDLE;
      // Channel 0 wins the first tie
      prev_chan <= chan_t'(1);
    end else begin
      state <= state_next;
      if (take && sel_last) begin
        prev_chan <= sel_chan;
      end
    end
  end

  // Output register with channel tag
  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
      out_last  <= 1'b0;
      out_data  <= '0;
      out_chan  <= '0;
    end else if (out_free) begin
      if (sel_valid) begin
        out_valid <= 1'b1;
        out_last  <= sel_last;
        out_data  <= sel_data;
        out_chan  <= sel_chan;
      end else begin
        out_valid <= 1'b0;
        out_last  <= 1'b0;
        out_data  <= '0;
        out_chan  <= '0;
      end
    end
  end

endmodule

/* logic/dual_capture_top.sv */
// Two-channel capture path with one receive buffer per channel and a packet merger.
// Write sides have no ready; the output is a tagged ready/valid stream.
`timescale 1ns/1ns

module dual_capture_top import capture_pkg::*; (
  input  logic    clk,
  input  logic    rst,

  // Channel 0 samples
  input  logic    ch0_valid,
  input  logic    ch0_last,
  input  sample_t ch0_data,

  // Channel 1 samples
  input  logic    ch1_valid,
  input  logic    ch1_last,
  input  sample_t ch1_data,

  // Merged stream
  output logic    out_valid,
  input  logic    out_ready,
  output logic    out_last,
  output sample_t out_data,
  output chan_t   out_chan
);

  // Buffer to merger streams
  sample_stream_if ch0_stream ();
  sample_stream_if ch1_stream ();

  stream_rx_buffer i_rx_buffer_ch0 (
    .clk      (clk),
    .rst      (rst),
    .ch_valid (ch0_valid),
    .ch_last  (ch0_last),
    .ch_data  (ch0_data),
    .out      (ch0_stream)
  );

  stream_rx_buffer i_rx_buffer_ch1 (
    .clk      (clk),
    .rst      (rst),
    .ch_valid (ch1_valid),
    .ch_last  (ch1_last),
    .ch_data  (ch1_data),
    .out      (ch1_stream)
  );

  packet_merge i_packet_merge (
    .clk       (clk),
    .rst       (rst),
    .ch0       (ch0_stream),
    .ch1       (ch1_stream),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_last  (out_last),
    .out_data  (out_data),
    .out_chan  (out_chan)
  );

endmodule

/* sim/stream_rx_buffer_properties.sv */
// Concurrent checks on the receive buffer, attached to every instance by the bind below.
`timescale 1ns/1ns

module stream_rx_buffer_properties import capture_pkg::*; (
  input logic     clk,
  input logic     rst,
  input logic     ch_valid,
  input logic     out_valid,
  input logic     out_ready,
  input logic     out_last,
  input sample_t  out_data,
  input buf_ptr_t wr_ptr,
  input buf_ptr_t rd_ptr
);

  // Samples written and not yet taken from the output register
  int outstanding;

  always_ff @(posedge clk) begin
    if (rst) begin
      outstanding <= 0;
    end else begin
      outstanding <= outstanding + int'(ch_valid) - int'(out_valid && out_ready);
    end
  end

  reset_state: assert property (@(posedge clk)
    rst |=> !out_valid && wr_ptr == '0 && rd_ptr == '0)
    else $error("Buffer output or pointers not cleared by reset");

  hold_on_stall: assert property (@(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> out_valid && $stable(out_last) && $stable(out_data))
    else $error("Buffer output changed while stalled");

  zero_when_idle: assert property (@(posedge clk) disable iff (rst)
    !out_valid |-> !out_last && out_data == '0)
    else $error("Buffer output not zero while not valid");

  wr_ptr_on_write: assert property (@(posedge clk) disable iff (rst)
    !ch_valid |=> $stable(wr_ptr))
    else $error("Write pointer moved without a write");

  // No read when the output is stalled or the bank is empty
  rd_ptr_on_read: assert property (@(posedge clk) disable iff (rst)
    (out_valid && !out_ready) || rd_ptr == wr_ptr |=> $stable(rd_ptr))
    else $error("Read pointer moved without a read");

  depth_limit: assert property (@(posedge clk) disable iff (rst)
    outstanding <= BUF_DEPTH)
    else $error("More samples outstanding than the buffer holds");

endmodule

bind stream_rx_buffer stream_rx_buffer_properties i_properties (
  .clk       (clk),
  .rst       (rst),
  .ch_valid  (ch_valid),
  .out_valid (out.valid),
  .out_ready (out.ready),
  .out_last  (out.last),
  .out_data  (out.data),
  .wr_ptr    (wr_ptr),
  .rd_ptr    (rd_ptr)
);

/* sim/dual_capture_tb.sv */
// Testbench for the two-channel capture path: random packets on both channels,
// one queue model per channel and checks on the merged output stream.
`timescale 1ns/1ns

module dual_capture_tb import capture_pkg::*; ();

  localparam int NUM_PACKETS    = 60;
  localparam int DRAIN_CYCLES   = 200;
  localparam int TIMEOUT_CYCLES = 2 * NUM_PACKETS * 40 + 1000;

  logic    clk;
  logic    rst;
  logic    ch_valid [2];
  logic    ch_last [2];
  sample_t ch_data [2];
  logic    out_valid;
  logic    out_ready;
  logic    out_last;
  sample_t out_data;
  chan_t   out_chan;

  // Expected {last, data} per channel
  logic [SAMPLE_W:0] exp_q0 [$];
  logic [SAMPLE_W:0] exp_q1 [$];

  // Per channel source state
  int beats_left [2] = '{0, 0};
  int gap [2] = '{0, 0};
  int sent [2] = '{0, 0};
  int outstanding [2] = '{0, 0};

  int      errors = 0;
  logic    hold_pending = 1'b0;
  logic    hold_last;
  sample_t hold_data;
  chan_t   hold_chan;
  logic    pkt_open = 1'b0;
  chan_t   open_chan;

  dual_capture_top i_dual_capture_top (
    .clk       (clk),
    .rst       (rst),
    .ch0_valid (ch_valid[0]),
    .ch0_last  (ch_last[0]),
    .ch0_data  (ch_data[0]),
    .ch1_valid (ch_valid[1]),
    .ch1_last  (ch_last[1]),
    .ch1_data  (ch_data[1]),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_last  (out_last),
    .out_data  (out_data),
    .out_chan  (out_chan)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("** Error %s: got %h, expected %h", name, got, exp);
    end
  endtask

  // One cycle of stimulus for one channel
  task automatic drive_channel(input int ch);
    ch_valid[ch] = 1'b0;
    ch_last[ch]  = 1'b0;
    ch_data[ch]  = '0;
    if (gap[ch] > 0) begin
      gap[ch]--;
    end else begin
      if (beats_left[ch] == 0 && sent[ch] < NUM_PACKETS) begin
        beats_left[ch] = 1 + int'($urandom % 6);
      end
      // Source pauses now and then inside a packet
      if (beats_left[ch] > 0 && outstanding[ch] < BUF_DEPTH && $urandom % 4 != 0) begin
        ch_valid[ch] = 1'b1;
        ch_last[ch]  = (beats_left[ch] == 1);
        ch_data[ch]  = sample_t'($urandom);
        if (ch == 0) begin
          exp_q0.push_back({ch_last[ch], ch_data[ch]});
        end else begin
          exp_q1.push_back({ch_last[ch], ch_data[ch]});
        end
        outstanding[ch]++;
        beats_left[ch]--;
        if (beats_left[ch] == 0) begin
          sent[ch]++;
          gap[ch] = int'($urandom % 5);
        end
      end
    end
  endtask

  task automatic check_accepted_beat();
    logic [SAMPLE_W:0] head;
    int                ch;
    logic              empty;
    ch    = int'(out_chan);
    empty = (ch == 0) ? (exp_q0.size() == 0) : (exp_q1.size() == 0);
    assert (!empty) else begin
      errors++;
      $display("Beat accepted on channel %0d while no sample was expected", ch);
    end
    if (!empty) begin
      if (ch == 0) begin
        head = exp_q0.pop_front();
      end else begin
        head = exp_q1.pop_front();
      end
      check_value("out_data", out_data, head[SAMPLE_W-1:0]);
      check_value("out_last", out_last, head[SAMPLE_W]);
      outstanding[ch]--;
    end
    // The other channel may not cut into an open packet
    if (pkt_open) begin
      assert (out_chan == open_chan) else begin
        errors++;
        $display("Channel %0d beat inside an open channel %0d packet", out_chan, open_chan);
      end
    end
    pkt_open  = !out_last;
    open_chan = out_chan;
  endtask

  // Output monitor on the falling edge
  always @(negedge clk) begin
    if (rst) begin
      hold_pending = 1'b0;
    end else begin
      if (hold_pending) begin
        check_value("out_valid", out_valid, 1);
        check_value("out_last", out_last, hold_last);
        check_value("out_data", out_data, hold_data);
        check_value("out_chan", out_chan, hold_chan);
      end
      hold_pending = out_valid && !out_ready;
      hold_last    = out_last;
      hold_data    = out_data;
      hold_chan    = out_chan;
      if (!out_valid) begin
        check_value("out_last", out_last, 0);
        check_value("out_data", out_data, 0);
      end
      if (out_valid && out_ready) begin
        check_accepted_beat();
      end
    end
  end

  initial begin : main_flow
    int cycles;
    void'($urandom(32'hb9d));
    rst       = 1'b1;
    out_ready = 1'b0;
    for (int ch = 0; ch < 2; ch++) begin
      ch_valid[ch] = 1'b0;
      ch_last[ch]  = 1'b0;
      ch_data[ch]  = '0;
    end
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    @(negedge clk);
    check_value("out_valid", out_valid, 0);
    while (sent[0] < NUM_PACKETS || sent[1] < NUM_PACKETS) begin
      @(posedge clk);
      #1;
      drive_channel(0);
      drive_channel(1);
      // Ready low about 30 percent of the time
      out_ready = ($urandom % 10) >= 3;
    end
    @(posedge clk);
    #1;
    for (int ch = 0; ch < 2; ch++) begin
      ch_valid[ch] = 1'b0;
      ch_last[ch]  = 1'b0;
      ch_data[ch]  = '0;
    end
    out_ready = 1'b1;
    cycles = 0;
    while ((exp_q0.size() > 0 || exp_q1.size() > 0) && cycles < DRAIN_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    assert (exp_q0.size() == 0 && exp_q1.size() == 0) else begin
      errors++;
      $display("Samples never came out: %0d on channel 0, %0d on channel 1",
               exp_q0.size(), exp_q1.size());
    end
    repeat (2) @(posedge clk);
    $display("Run complete with %0d errors", errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(TIMEOUT_CYCLES * 10);
    $display("Timeout after %0d cycles, the run did not finish", TIMEOUT_CYCLES);
    $display("Errors found");
    $finish;
  end

endmodule

/* sources.f */
logic/capture_pkg.sv
logic/sample_stream_if.sv
logic/stream_rx_buffer.sv
logic/packet_merge.sv
logic/dual_capture_top.sv
sim/stream_rx_buffer_properties.sv
sim/dual_capture_tb.sv

/* Bender.yml */
package:
  name: dual_capture

sources:
  - logic/capture_pkg.sv
  - logic/sample_stream_if.sv
  - logic/stream_rx_buffer.sv
  - logic/packet_merge.sv
  - logic/dual_capture_top.sv
  - target: simulation
    files:
      - sim/stream_rx_buffer_properties.sv
      - sim/dual_capture_tb.sv
